// ==== hdl/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
  input  logic            clk,
  input  logic            rst_n,
  input  rv_pkg::word_t   inst,
  output rv_pkg::word_t   pc,
  output rv_pkg::wb_m2s_t wb_o,
  input  rv_pkg::wb_s2m_t wb_i,
  output logic            halt
);
  import rv_pkg::*;

  ctrl_t ctrl;
  word_t rs1_data;
  word_t rs2_data;
  word_t mem_addr;   // adder result
  word_t load_data;
  word_t rd_data;
  logic  rd_we;
  logic  stall;

  rv_decoder u_decoder (
    .inst (inst),
    .ctrl (ctrl)
  );

  rv_regfile u_regfile (
    .clk    (clk),
    .rst_n  (rst_n),
    .we     (rd_we),
    .waddr  (ctrl.rd),
    .raddr1 (ctrl.rs1),
    .raddr2 (ctrl.rs2),
    .wdata  (rd_data),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  rv_execute u_execute (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl),
    .rs1_data  (rs1_data),
    .stall     (stall),
    .halt      (ctrl.halt),
    .load_data (load_data),
    .pc        (pc),
    .addr      (mem_addr),
    .rd_we     (rd_we),
    .rd_data   (rd_data)
  );

  rv_lsu u_lsu (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl),
    .addr       (mem_addr),
    .store_data (rs2_data),
    .wb_o       (wb_o),
    .wb_i       (wb_i),
    .stall      (stall),
    .load_data  (load_data)
  );

  assign halt = ctrl.halt;  // ebreak, straight from decode

endmodule

// ==== hdl/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
  input  rv_pkg::word_t inst,
  output rv_pkg::ctrl_t ctrl
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_u;
  word_t      imm_j;
  logic       is_addi;
  logic       is_ebreak;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];

  // sign extension always from bit 31
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  assign is_addi   = (opcode == op_imm) && (funct3 == 3'b000);
  assign is_ebreak = (opcode == op_system) && (inst[31:7] == {12'h001, 13'h0000});

  always_comb begin
    ctrl           = '0;
    ctrl.op_a      = op_a_rs1;
    ctrl.wb_src    = wb_alu;
    ctrl.mem_f3    = funct3;
    ctrl.rd        = inst[11:7];
    ctrl.rs1       = inst[19:15];
    ctrl.rs2       = inst[24:20];
    ctrl.halt      = is_ebreak;

    unique case (opcode)
      op_imm: begin
        ctrl.imm    = imm_i;
        ctrl.reg_we = is_addi;  // other op-imm functions retire as no-op
      end
      op_lui: begin
        ctrl.imm    = imm_u;
        ctrl.rs1    = '0;  // x0 reads zero, so the adder passes imm through
        ctrl.reg_we = 1'b1;
      end
      op_auipc: begin
        ctrl.imm    = imm_u;
        ctrl.op_a   = op_a_pc;
        ctrl.reg_we = 1'b1;
      end
      op_jal: begin
        ctrl.imm    = imm_j;
        ctrl.op_a   = op_a_pc;
        ctrl.jump   = 1'b1;
        ctrl.reg_we = 1'b1;
        ctrl.wb_src = wb_pc4;
      end
      op_jalr: begin
        ctrl.imm    = imm_i;
        ctrl.jump   = 1'b1;
        ctrl.reg_we = 1'b1;
        ctrl.wb_src = wb_pc4;
      end
      op_load: begin
        ctrl.imm      = imm_i;
        ctrl.mem_read = 1'b1;
        ctrl.reg_we   = 1'b1;
        ctrl.wb_src   = wb_mem;
      end
      op_store: begin
        ctrl.imm       = imm_s;
        ctrl.mem_write = 1'b1;
      end
      default: ;  // unknown opcode, plain pc + 4
    endcase
  end

endmodule

// ==== hdl/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute (
  input  logic          clk,
  input  logic          rst_n,
  input  rv_pkg::ctrl_t ctrl,
  input  rv_pkg::word_t rs1_data,
  input  logic          stall,
  input  logic          halt,
  input  rv_pkg::word_t load_data,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t addr,
  output logic          rd_we,
  output rv_pkg::word_t rd_data
);
  import rv_pkg::*;

  word_t pc_q;
  word_t pc_plus4;
  word_t op_a_val;
  word_t sum;
  word_t jump_target;
  word_t pc_next;

  assign pc_plus4 = pc_q + xlen'(4);

  // one shared adder
  assign op_a_val = (ctrl.op_a == op_a_pc) ? pc_q : rs1_data;
  assign sum      = op_a_val + ctrl.imm;
  assign addr     = sum;

  // jalr clears bit 0, jal targets are even anyway
  assign jump_target = {sum[xlen-1:1], 1'b0};

  assign pc_next = ctrl.jump ? jump_target : pc_plus4;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= reset_vector;
    end else if (!stall && !halt) begin
      pc_q <= pc_next;
    end
  end

  assign pc = pc_q;

  always_comb begin
    unique case (ctrl.wb_src)
      wb_pc4:  rd_data = pc_plus4;
      wb_mem:  rd_data = load_data;
      default: rd_data = sum;
    endcase
  end

  assign rd_we = ctrl.reg_we & ~stall;  // loads write in the done cycle only

endmodule

// ==== hdl/rv_lsu.sv ====
`timescale 1ns/1ps

module rv_lsu (
  input  logic            clk,
  input  logic            rst_n,
  input  rv_pkg::ctrl_t   ctrl,
  input  rv_pkg::word_t   addr,
  input  rv_pkg::word_t   store_data,
  output rv_pkg::wb_m2s_t wb_o,
  input  rv_pkg::wb_s2m_t wb_i,
  output logic            stall,
  output rv_pkg::word_t   load_data
);
  import rv_pkg::*;

  lsu_state_e state;
  logic       mem_req;
  sel_t       sel_req;
  word_t      dat_req;

  // request payload, held for the whole bus cycle
  word_t      adr_q;
  word_t      dat_q;
  sel_t       sel_q;
  logic       we_q;
  logic [1:0] lane_q;
  word_t      rdata_q;
  word_t      lane_data;

  assign mem_req = ctrl.mem_read | ctrl.mem_write;

  // byte select and lane replication, zero sel when misaligned
  always_comb begin
    sel_req = '0;
    dat_req = store_data;
    unique case (ctrl.mem_f3)
      f3_byte, f3_byte_u: begin
        sel_req = 4'b0001 << addr[1:0];
        dat_req = {4{store_data[7:0]}};
      end
      f3_half, f3_half_u: begin
        if (!addr[0]) begin
          sel_req = 4'b0011 << addr[1:0];
        end
        dat_req = {2{store_data[15:0]}};
      end
      f3_word: begin
        if (addr[1:0] == 2'b00) begin
          sel_req = 4'b1111;
        end
      end
      default: ;
    endcase
    if (ctrl.mem_write && ctrl.mem_f3[2]) begin
      sel_req = '0;  // no unsigned stores
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= lsu_idle;
    end else begin
      unique case (state)
        lsu_idle: begin
          if (mem_req) begin
            state <= (sel_req != '0) ? lsu_busy : lsu_done;  // misaligned skips the bus
          end
        end
        lsu_busy: begin
          if (wb_i.ack) begin
            state <= lsu_done;
          end
        end
        default: state <= lsu_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == lsu_idle && mem_req) begin
      adr_q   <= {addr[xlen-1:2], 2'b00};
      dat_q   <= dat_req;
      sel_q   <= sel_req;
      we_q    <= ctrl.mem_write;
      lane_q  <= addr[1:0];
      rdata_q <= '0;  // misaligned loads return zero
    end else if (state == lsu_busy && wb_i.ack) begin
      rdata_q <= wb_i.dat;
    end
  end

  always_comb begin
    wb_o.cyc = (state == lsu_busy);
    wb_o.stb = (state == lsu_busy);
    wb_o.we  = we_q;
    wb_o.adr = adr_q;
    wb_o.dat = dat_q;
    wb_o.sel = sel_q;
  end

  assign stall = mem_req && (state != lsu_done);

  // load lane extraction
  assign lane_data = rdata_q >> {lane_q, 3'b000};

  always_comb begin
    unique case (ctrl.mem_f3)
      f3_byte:   load_data = {{(xlen-8){lane_data[7]}}, lane_data[7:0]};
      f3_half:   load_data = {{(xlen-16){lane_data[15]}}, lane_data[15:0]};
      f3_word:   load_data = rdata_q;
      f3_byte_u: load_data = {{(xlen-8){1'b0}}, lane_data[7:0]};
      f3_half_u: load_data = {{(xlen-16){1'b0}}, lane_data[15:0]};
      default:   load_data = '0;
    endcase
  end

endmodule

// ==== hdl/rv_pkg.sv ====
package rv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [3:0]      sel_t;

  localparam word_t reset_vector = 32'h8000_0000;

  // opcode classes the core executes
  localparam logic [6:0] op_lui    = 7'b011_0111;
  localparam logic [6:0] op_auipc  = 7'b001_0111;
  localparam logic [6:0] op_jal    = 7'b110_1111;
  localparam logic [6:0] op_jalr   = 7'b110_0111;
  localparam logic [6:0] op_load   = 7'b000_0011;
  localparam logic [6:0] op_store  = 7'b010_0011;
  localparam logic [6:0] op_imm    = 7'b001_0011;
  localparam logic [6:0] op_system = 7'b111_0011;

  // funct3 width codes for loads and stores
  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  typedef enum logic {
    op_a_rs1,
    op_a_pc
  } op_a_e;

  typedef enum logic [1:0] {
    wb_alu,  // adder result
    wb_pc4,  // link value
    wb_mem   // load data
  } wb_src_e;

  typedef struct packed {
    op_a_e     op_a;
    word_t     imm;
    logic      reg_we;
    wb_src_e   wb_src;
    logic      jump;
    logic      mem_read;
    logic      mem_write;
    logic [2:0] mem_f3;
    logic      halt;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
  } ctrl_t;

  // wishbone classic, master to slave
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    word_t adr;
    word_t dat;
    sel_t  sel;
  } wb_m2s_t;

  typedef struct packed {
    logic  ack;
    word_t dat;
  } wb_s2m_t;

  typedef enum logic [1:0] {
    lsu_idle,
    lsu_busy,
    lsu_done
  } lsu_state_e;

endpackage

// ==== hdl/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              we,
  input  rv_pkg::reg_addr_t waddr,
  input  rv_pkg::reg_addr_t raddr1,
  input  rv_pkg::reg_addr_t raddr2,
  input  rv_pkg::word_t     wdata,
  output rv_pkg::word_t     rdata1,
  output rv_pkg::word_t     rdata2
);
  import rv_pkg::*;

  word_t regs [1:31];  // x0 has no storage

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // combinational read ports
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_rv_core -Mdir obj_dir; then
  echo "build failed"
  exit 1
fi

obj_dir/Vtb_rv_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test OK" sim.log; then
  exit 0
fi
exit 1

// ==== verification/rv_core_asserts.sv ====
`timescale 1ns/1ps

module rv_core_asserts (
  input logic            clk,
  input logic            rst_n,
  input rv_pkg::wb_m2s_t wb_o,
  input rv_pkg::wb_s2m_t wb_i,
  input rv_pkg::word_t   pc,
  input logic            halt
);

  stb_needs_cyc: assert property (@(posedge clk) disable iff (!rst_n)
    wb_o.stb |-> wb_o.cyc)
    else $error("stb high without cyc");

  // request held until the slave acks
  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_o.cyc && !wb_i.ack) |=> ($stable(wb_o.adr) && $stable(wb_o.dat)
                                 && $stable(wb_o.sel) && $stable(wb_o.we)))
    else $error("bus request changed before ack");

  sel_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    wb_o.cyc |-> (wb_o.sel != 4'b0000))
    else $error("bus cycle with zero sel");

  halt_holds_pc: assert property (@(posedge clk) disable iff (!rst_n)
    halt |=> $stable(pc))
    else $error("pc moved while halted");

endmodule

bind rv_core rv_core_asserts u_asserts (.*);

// ==== verification/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;
  import rv_pkg::*;

  logic    clk;
  logic    rst_n;
  word_t   inst;
  word_t   pc;
  wb_m2s_t wb_o;
  wb_s2m_t wb_i;
  logic    halt;

  word_t mem [0:63];  // slave memory, index adr[7:2]
  logic [31:0] lcg_state = 32'd44729;

  // program table, one entry per instruction
  word_t  row_inst [$];
  word_t  row_pc   [$];
  logic   row_st   [$];
  word_t  row_adr  [$];
  word_t  row_dat  [$];
  sel_t   row_sel  [$];
  string  row_name [$];

  word_t  mregs [0:31];  // register model used while building the table
  word_t  mpc;
  int     cur_row;
  int     row_errs;
  int     n_pass;
  int     n_fail;
  int     wait_cnt;
  int     cycles;
  logic   store_seen;
  logic   table_ready = 1'b0;
  word_t  old_pc;
  longint wd_ns;
  logic [2:0] ld_f3s [0:4];

  rv_core dut0 (
    .clk   (clk),
    .rst_n (rst_n),
    .inst  (inst),
    .pc    (pc),
    .wb_o  (wb_o),
    .wb_i  (wb_i),
    .halt  (halt)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {16'h0000, lcg_state[30:15]};
  endfunction

  // two lcg draws per memory word
  function automatic word_t rand_word();
    word_t hi;
    hi = lcg_next();
    return (hi << 16) | lcg_next();
  endfunction

  function automatic word_t enc_i(int imm, int rs1, logic [2:0] f3, int rd, logic [6:0] op);
    logic [31:0] im;
    im = imm;
    return {im[11:0], 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic word_t enc_s(int imm, int rs2, int rs1, logic [2:0] f3);
    logic [31:0] im;
    im = imm;
    return {im[11:5], 5'(rs2), 5'(rs1), f3, im[4:0], op_store};
  endfunction

  function automatic word_t enc_j(int imm, int rd);
    logic [31:0] im;
    im = imm;
    return {im[20], im[10:1], im[11], im[19:12], 5'(rd), op_jal};
  endfunction

  function automatic word_t sel_mask(sel_t s);
    return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
  endfunction

  // lane pick and extension as the load rules say
  function automatic word_t load_expect(logic [2:0] f3, word_t w, logic [1:0] off);
    word_t sh;
    sh = w >> (8 * off);
    case (f3)
      f3_byte:   return {{24{sh[7]}}, sh[7:0]};
      f3_half:   return {{16{sh[15]}}, sh[15:0]};
      f3_byte_u: return {24'h000000, sh[7:0]};
      f3_half_u: return {16'h0000, sh[15:0]};
      default:   return w;
    endcase
  endfunction

  task automatic push_row(word_t ins, string nm, logic st, word_t adr, word_t dat, sel_t sel);
    row_inst.push_back(ins);
    row_pc.push_back(mpc);  // pc after the instruction retires
    row_st.push_back(st);
    row_adr.push_back(adr);
    row_dat.push_back(dat);
    row_sel.push_back(sel);
    row_name.push_back(nm);
  endtask

  task automatic do_addi(int rd, int rs1, int imm, string nm);
    if (rd != 0) mregs[rd] = mregs[rs1] + word_t'(imm);
    mpc = mpc + 4;
    push_row(enc_i(imm, rs1, 3'b000, rd, op_imm), nm, 1'b0, '0, '0, '0);
  endtask

  task automatic do_upper(logic [6:0] op, int rd, logic [19:0] u, string nm);
    word_t v;
    v = {u, 12'h000};
    if (op == op_auipc) v = v + mpc;
    if (rd != 0) mregs[rd] = v;
    mpc = mpc + 4;
    push_row({u, 5'(rd), op}, nm, 1'b0, '0, '0, '0);
  endtask

  task automatic do_jal(int rd, int off, string nm);
    word_t link;
    link = mpc + 4;
    mpc = mpc + word_t'(off);
    if (rd != 0) mregs[rd] = link;
    push_row(enc_j(off, rd), nm, 1'b0, '0, '0, '0);
  endtask

  task automatic do_jalr(int rd, int rs1, int imm, string nm);
    word_t target;
    word_t link;
    target = (mregs[rs1] + word_t'(imm)) & ~32'h1;
    link = mpc + 4;
    if (rd != 0) mregs[rd] = link;
    mpc = target;
    push_row(enc_i(imm, rs1, 3'b000, rd, op_jalr), nm, 1'b0, '0, '0, '0);
  endtask

  task automatic do_store(logic [2:0] f3, int rs2, int rs1, int imm, string nm);
    word_t a;
    word_t v;
    sel_t  s;
    a = mregs[rs1] + word_t'(imm);
    case (f3)
      f3_byte: begin
        s = 4'b0001 << a[1:0];
        v = (mregs[rs2] & 32'h0000_00ff) << (8 * a[1:0]);
      end
      f3_half: begin
        s = 4'b0011 << a[1:0];
        v = (mregs[rs2] & 32'h0000_ffff) << (8 * a[1:0]);
      end
      default: begin
        s = 4'b1111;
        v = mregs[rs2];
      end
    endcase
    mpc = mpc + 4;
    push_row(enc_s(imm, rs2, rs1, f3), nm, 1'b1, {a[31:2], 2'b00}, v, s);
  endtask

  task automatic do_load(logic [2:0] f3, int rd, int rs1, int imm, string nm);
    word_t a;
    a = mregs[rs1] + word_t'(imm);
    if (rd != 0) mregs[rd] = load_expect(f3, mem[a[7:2]], a[1:0]);
    mpc = mpc + 4;
    push_row(enc_i(imm, rs1, f3, rd, op_load), nm, 1'b0, '0, '0, '0);
  endtask

  task automatic build_program();
    int idx;
    int off;
    ld_f3s = '{f3_byte, f3_half, f3_word, f3_byte_u, f3_half_u};
    foreach (mregs[i]) mregs[i] = '0;
    mpc = reset_vector;
    do_addi(1, 0, 'h100, "addi base store");  // store region, words 0..15
    do_addi(2, 0, 'h180, "addi base load");   // load region, words 32..63
    do_upper(op_lui, 3, 20'h12345, "lui");
    do_store(f3_word, 3, 1, 0, "sw lui result");
    do_upper(op_auipc, 4, 20'h00001, "auipc");
    do_store(f3_word, 4, 1, 4, "sw auipc result");
    do_addi(5, 3, -5, "addi negative");
    do_store(f3_word, 5, 1, 8, "sw addi result");
    do_addi(6, 0, -2048, "addi min imm");
    do_store(f3_word, 6, 1, 12, "sw addi min");
    do_jal(7, 16, "jal forward");
    do_store(f3_word, 7, 1, 0, "sw jal link");
    do_upper(op_auipc, 8, 20'h00000, "auipc for jalr");
    do_jalr(9, 8, 13, "jalr odd target");
    do_store(f3_word, 9, 1, 4, "sw jalr link");
    for (int o = 0; o < 4; o++) do_store(f3_byte, 5, 1, 16 + o, $sformatf("sb offset %0d", o));
    for (int o = 0; o < 4; o += 2) do_store(f3_half, 5, 1, 20 + o, $sformatf("sh offset %0d", o));
    do_store(f3_word, 5, 1, 24, "sw offset 0");
    for (int k = 0; k < 10; k++) begin
      idx = int'(lcg_next() % 32);
      case (ld_f3s[k % 5])
        f3_byte, f3_byte_u: off = int'(lcg_next() % 4);
        f3_half, f3_half_u: off = int'(lcg_next() % 2) * 2;
        default:            off = 0;
      endcase
      do_load(ld_f3s[k % 5], 10, 2, idx * 4 + off,
              $sformatf("load f3 %0d word %0d", ld_f3s[k % 5], idx));
      do_store(f3_word, 10, 1, 28, $sformatf("sw load result %0d", k));
    end
    mpc = mpc + 4;
    push_row(32'h0000_01b3, "r-type no-op", 1'b0, '0, '0, '0);  // add x3, x0, x0
    do_store(f3_word, 3, 1, 0, "sw after no-op");  // x3 keeps the lui value
    push_row(32'h0010_0073, "ebreak", 1'b0, '0, '0, '0);  // pc stays put
  endtask

  task automatic report_fail(string msg);
    $display("FAIL t=%0t: %s", $time, msg);
    row_errs++;
  endtask

  // wishbone slave with random wait states
  initial begin
    wb_i = '0;
    wait_cnt = 0;
    forever begin
      @(posedge clk);
      #1;
      wb_i.ack = 1'b0;
      if (rst_n && wb_o.cyc && wb_o.stb) begin
        if (wait_cnt > 0) begin
          wait_cnt--;
        end else begin
          if (wb_o.we) begin
            store_seen = 1'b1;
            if (!row_st[cur_row] || wb_o.adr !== row_adr[cur_row] || wb_o.sel !== row_sel[cur_row]
                || ((wb_o.dat ^ row_dat[cur_row]) & sel_mask(wb_o.sel)) != 0) begin
              report_fail($sformatf("%s: store adr %h dat %h sel %b, expected %h %h %b",
                          row_name[cur_row], wb_o.adr, wb_o.dat, wb_o.sel,
                          row_adr[cur_row], row_dat[cur_row], row_sel[cur_row]));
            end
            mem[wb_o.adr[7:2]] = (mem[wb_o.adr[7:2]] & ~sel_mask(wb_o.sel))
                               | (wb_o.dat & sel_mask(wb_o.sel));
          end else begin
            wb_i.dat = mem[wb_o.adr[7:2]];
          end
          wb_i.ack = 1'b1;
          wait_cnt = int'(lcg_next() % 4);
        end
      end
    end
  end

  initial begin
    wait (table_ready);
    wd_ns = (longint'(row_inst.size()) * 10 + 16) * 100;
    #(wd_ns);
    $display("timeout: the program did not finish within the watchdog limit");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    inst = 32'h0000_0013;  // nop while in reset
    rst_n = 1'b0;
    n_pass = 0;
    n_fail = 0;
    cur_row = 0;
    row_errs = 0;
    store_seen = 1'b0;
    foreach (mem[i]) mem[i] = rand_word();
    build_program();
    table_ready = 1'b1;
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;
    if (pc !== reset_vector || wb_o.cyc !== 1'b0) begin
      report_fail($sformatf("after reset pc %h cyc %b", pc, wb_o.cyc));
    end
    if (row_errs == 0) n_pass++;
    else n_fail++;
    $display("%s: reset state", (row_errs == 0) ? "pass" : "failed");
    for (int r = 0; r < row_inst.size(); r++) begin
      cur_row = r;
      row_errs = 0;
      store_seen = 1'b0;
      old_pc = pc;
      inst = row_inst[r];
      cycles = 0;
      if (r == row_inst.size() - 1) begin
        #1;
        if (halt !== 1'b1) report_fail("halt not raised for ebreak");
        repeat (5) begin
          @(posedge clk);
          #1;
          if (pc !== row_pc[r] || wb_o.cyc !== 1'b0) begin
            report_fail($sformatf("while halted pc %h cyc %b", pc, wb_o.cyc));
          end
        end
      end else begin
        do begin
          @(posedge clk);
          #1;
          cycles++;
        end while (pc == old_pc && cycles < 20);
        if (pc !== row_pc[r]) begin
          report_fail($sformatf("%s: pc %h, expected %h", row_name[r], pc, row_pc[r]));
        end
        if (row_st[r] && !store_seen) begin
          report_fail($sformatf("%s: the store never reached the bus", row_name[r]));
        end
      end
      if (row_errs == 0) n_pass++;
      else n_fail++;
      $display("%s: %s", (row_errs == 0) ? "pass" : "failed", row_name[r]);
    end
    $display("tests passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_lsu.sv
hdl/rv_core.sv
verification/rv_core_asserts.sv
verification/tb_rv_core.sv
